//--- logic/alu.sv
`timescale 1ns/100ps

module alu import rv_pkg::*; (
    input  word_t      a_i,
    input  word_t      b_i,
    input  logic [2:0] funct3_i,
    input  logic [6:0] funct7_i,
    input  logic       use_imm_i,
    output word_t      result_o,
    output logic       zero_o,
    output logic       negative_o,
    output logic       carry_o,
    output logic       overflow_o
);

    logic        sub;
    word_t       b_eff;
    logic [32:0] sum;
    logic [4:0]  shamt;

    // addi never subtracts, slt/sltu always do
    assign sub = (funct3_i inside {3'b010, 3'b011}) ||
                 (funct3_i == 3'b000 && funct7_i == ALU_SUB_FUNCT7 && !use_imm_i);

    assign b_eff = sub ? ~b_i : b_i;
    assign sum   = {1'b0, a_i} + {1'b0, b_eff} + {32'b0, sub};
    assign shamt = b_i[4:0];

    // flags from the adder; carry set means no borrow on subtract
    assign zero_o     = sum[31:0] == '0;
    assign negative_o = sum[31];
    assign carry_o    = sum[32];
    assign overflow_o = (a_i[31] == b_eff[31]) && (sum[31] != a_i[31]);

    always_comb begin
        case (funct3_i)
            3'b000:  result_o = sum[31:0];
            3'b001:  result_o = a_i << shamt;
            3'b010:  result_o = {31'b0, negative_o ^ overflow_o};  // slt
            3'b011:  result_o = {31'b0, !carry_o};                 // sltu
            3'b100:  result_o = a_i ^ b_i;
            3'b101:  result_o = (funct7_i == ALU_SUB_FUNCT7) ?
                                word_t'($signed(a_i) >>> shamt) : (a_i >> shamt);
            3'b110:  result_o = a_i | b_i;
            default: result_o = a_i & b_i;
        endcase
    end

endmodule

//--- logic/decoder.sv
`timescale 1ns/100ps

module decoder import rv_pkg::*; (
    input  fetch_t   in_i,
    output decoded_t out_o
);

    word_t ins;
    word_t imm_i, imm_u, imm_b, imm_j;

    assign ins = in_i.instr;

    // immediate formats
    assign imm_i = {{20{ins[31]}}, ins[31:20]};
    assign imm_u = {ins[31:12], 12'b0};
    assign imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
    assign imm_j = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};

    always_comb begin
        out_o       = '0;
        out_o.valid = in_i.valid;
        out_o.instr = ins;
        out_o.pc    = in_i.pc;

        // unused register fields stay zero, so no false dependences
        if (ins[1:0] == 2'b11) begin
            out_o.opcode = opcode_e'(ins[6:2]);
            case (opcode_e'(ins[6:2]))
                OP: begin
                    out_o.rs1    = ins[19:15];
                    out_o.rs2    = ins[24:20];
                    out_o.rd     = ins[11:7];
                    out_o.funct3 = ins[14:12];
                    out_o.funct7 = ins[31:25];
                end
                OP_IMM: begin
                    out_o.rs1    = ins[19:15];
                    out_o.rd     = ins[11:7];
                    out_o.imm    = imm_i;
                    out_o.funct3 = ins[14:12];
                    out_o.funct7 = ins[31:25];  // only srai looks at it
                end
                LUI, AUIPC: begin
                    out_o.rd  = ins[11:7];
                    out_o.imm = imm_u;
                end
                BRANCH: begin
                    out_o.rs1    = ins[19:15];
                    out_o.rs2    = ins[24:20];
                    out_o.imm    = imm_b;
                    out_o.funct3 = 3'b000;          // compare by subtract
                    out_o.funct7 = ALU_SUB_FUNCT7;
                end
                JAL: begin
                    out_o.rd  = ins[11:7];
                    out_o.imm = imm_j;
                end
                JALR: begin
                    out_o.rs1 = ins[19:15];
                    out_o.rd  = ins[11:7];
                    out_o.imm = imm_i;
                end
                default: ;  // retires as a no-op
            endcase
        end

        out_o.we = out_o.rd != '0;  // x0 writes are dropped here
    end

endmodule

//--- logic/execute_unit.sv
`timescale 1ns/100ps

module execute_unit import rv_pkg::*; (
    input  decoded_t ex_i,
    output wb_t      out_o
);

    logic  use_imm;
    word_t alu_b, alu_res;
    logic  zero, neg, carry, ovf;
    logic  taken;
    word_t pc_imm, link, jalr_sum;

    assign use_imm = ex_i.opcode == OP_IMM;
    assign alu_b   = use_imm ? ex_i.imm : ex_i.r2;

    alu u_alu (
        .a_i        (ex_i.r1),
        .b_i        (alu_b),
        .funct3_i   (ex_i.funct3),
        .funct7_i   (ex_i.funct7),
        .use_imm_i  (use_imm),
        .result_o   (alu_res),
        .zero_o     (zero),
        .negative_o (neg),
        .carry_o    (carry),
        .overflow_o (ovf)
    );

    assign pc_imm   = ex_i.pc + ex_i.imm;   // branch, jal, auipc
    assign link     = ex_i.pc + 32'd4;
    assign jalr_sum = ex_i.r1 + ex_i.imm;

    // branch condition from the original funct3 field
    always_comb begin
        case (ex_i.instr[14:12])
            3'b000:  taken = zero;          // beq
            3'b001:  taken = !zero;         // bne
            3'b100:  taken = neg ^ ovf;     // blt
            3'b101:  taken = !(neg ^ ovf);  // bge
            3'b110:  taken = !carry;        // bltu
            3'b111:  taken = carry;         // bgeu
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        out_o       = '0;
        out_o.valid = ex_i.valid;
        out_o.pc    = ex_i.pc;
        out_o.rd    = ex_i.rd;
        out_o.we    = ex_i.we;
        case (ex_i.opcode)
            OP, OP_IMM: out_o.result = alu_res;
            LUI:        out_o.result = ex_i.imm;
            AUIPC:      out_o.result = pc_imm;
            BRANCH: begin
                out_o.redirect = taken;
                out_o.target   = pc_imm;
            end
            JAL: begin
                out_o.result   = link;
                out_o.redirect = 1'b1;
                out_o.target   = pc_imm;
            end
            JALR: begin
                out_o.result   = link;
                out_o.redirect = 1'b1;
                out_o.target   = {jalr_sum[31:1], 1'b0};
            end
            default: ;
        endcase
    end

endmodule

//--- logic/fetch_unit.sv
`timescale 1ns/100ps

module fetch_unit import rv_pkg::*; #(
    parameter word_t INITIAL_PC = '0
) (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   stall_i,
    input  logic   redirect_i,
    input  word_t  redirect_pc_i,
    input  logic   imem_ready_i,
    input  word_t  imem_rdata_i,
    output logic   imem_valid_o,
    output word_t  imem_addr_o,
    output fetch_t fetched_o,
    output logic   fetched_valid_o
);

    logic  run_q;   // low until the first edge after reset
    word_t addr_q;

    assign imem_valid_o    = run_q && !stall_i;
    assign imem_addr_o     = addr_q;
    assign fetched_valid_o = imem_valid_o && imem_ready_i;

    always_comb begin
        fetched_o.valid = fetched_valid_o;
        fetched_o.instr = imem_rdata_i;
        fetched_o.pc    = addr_q;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            run_q  <= 1'b0;
            addr_q <= INITIAL_PC;
        end else begin
            run_q <= 1'b1;
            if (redirect_i) begin
                addr_q <= redirect_pc_i;
            end else if (fetched_valid_o) begin
                addr_q <= addr_q + 32'd4;  // predict not taken
            end
        end
    end

endmodule

//--- logic/hazard_unit.sv
`timescale 1ns/100ps

module hazard_unit import rv_pkg::*; (
    input  decoded_t dec_i,
    input  decoded_t ex_i,
    wb_if.sink       wb,
    input  word_t    rf_r1_i,
    input  word_t    rf_r2_i,
    output word_t    op1_o,
    output word_t    op2_o,
    output logic     stall_o
);

    logic fwd1, fwd2;
    logic ex_writes;

    // ------------------------------------------------------------------
    // forwarding from writeback
    // ------------------------------------------------------------------

    assign fwd1 = wb.valid && (wb.rd != '0) && (wb.rd == dec_i.rs1);
    assign fwd2 = wb.valid && (wb.rd != '0) && (wb.rd == dec_i.rs2);

    assign op1_o = fwd1 ? wb.data : rf_r1_i;
    assign op2_o = fwd2 ? wb.data : rf_r2_i;

    // ------------------------------------------------------------------
    // dependence on execute
    // ------------------------------------------------------------------

    // result not ready until it sits in writeback, one cycle later
    assign ex_writes = ex_i.valid && ex_i.we && (ex_i.rd != '0);

    assign stall_o = dec_i.valid && ex_writes &&
                     ((ex_i.rd == dec_i.rs1) || (ex_i.rd == dec_i.rs2));

endmodule

//--- logic/pipe_reg.sv
`timescale 1ns/100ps

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     flush_i,
    input  logic     stall_i,
    input  logic     bubble_i,
    input  payload_t d_i,
    output payload_t q_o
);

    // flush beats stall, stall beats bubble
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q_o <= '0;
        end else if (flush_i) begin
            q_o <= '0;
        end else if (!stall_i) begin
            if (bubble_i) begin
                q_o <= '0;  // all-zero payload is an empty slot
            end else begin
                q_o <= d_i;
            end
        end
    end

endmodule

//--- logic/reg_file.sv
`timescale 1ns/100ps

module reg_file import rv_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  reg_idx_t rs1_i,
    input  reg_idx_t rs2_i,
    wb_if.sink       wb,
    output word_t    r1_o,
    output word_t    r2_o
);

    word_t regs [1:31];  // x0 has no storage

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid && (wb.rd != '0)) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // same-cycle write is covered by the hazard unit bypass
    assign r1_o = (rs1_i == '0) ? '0 : regs[rs1_i];
    assign r2_o = (rs2_i == '0) ? '0 : regs[rs2_i];

endmodule

//--- logic/rv_core.sv
`timescale 1ns/100ps

module rv_core import rv_pkg::*; #(
    parameter word_t INITIAL_PC = '0
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     imem_ready_i,
    input  word_t    imem_rdata_i,
    output logic     imem_valid_o,
    output word_t    imem_addr_o,
    output logic     retire_valid_o,
    output word_t    retire_pc_o,
    output reg_idx_t retire_rd_o,
    output word_t    retire_data_o
);

    fetch_t   fd_d, fd_q;
    logic     fd_valid;
    decoded_t dec, dec_ops, de_q;
    wb_t      ex_out, wb_q;
    word_t    rf_r1, rf_r2, op1, op2;
    logic     stall;

    wb_if wbus ();

    // ------------------------------------------------------------------
    // fetch and fetch/decode
    // ------------------------------------------------------------------

    fetch_unit #(.INITIAL_PC(INITIAL_PC)) u_fetch (
        .clk(clk), .rst_n(rst_n),
        .stall_i(stall), .redirect_i(wb_q.redirect), .redirect_pc_i(wb_q.target),
        .imem_ready_i(imem_ready_i), .imem_rdata_i(imem_rdata_i),
        .imem_valid_o(imem_valid_o), .imem_addr_o(imem_addr_o),
        .fetched_o(fd_d), .fetched_valid_o(fd_valid)
    );

    pipe_reg #(.payload_t(fetch_t)) u_fd (
        .clk(clk), .rst_n(rst_n), .flush_i(wb_q.redirect),
        .stall_i(stall), .bubble_i(!fd_valid), .d_i(fd_d), .q_o(fd_q)
    );

    // ------------------------------------------------------------------
    // decode and decode/execute
    // ------------------------------------------------------------------

    decoder u_dec (.in_i(fd_q), .out_o(dec));

    reg_file u_rf (
        .clk(clk), .rst_n(rst_n), .rs1_i(dec.rs1), .rs2_i(dec.rs2),
        .wb(wbus), .r1_o(rf_r1), .r2_o(rf_r2)
    );

    hazard_unit u_hz (
        .dec_i(dec), .ex_i(de_q), .wb(wbus), .rf_r1_i(rf_r1), .rf_r2_i(rf_r2),
        .op1_o(op1), .op2_o(op2), .stall_o(stall)
    );

    always_comb begin
        dec_ops    = dec;
        dec_ops.r1 = op1;
        dec_ops.r2 = op2;
    end

    pipe_reg #(.payload_t(decoded_t)) u_de (
        .clk(clk), .rst_n(rst_n), .flush_i(wb_q.redirect),
        .stall_i(1'b0), .bubble_i(stall), .d_i(dec_ops), .q_o(de_q)
    );

    // ------------------------------------------------------------------
    // execute, execute/writeback and retire
    // ------------------------------------------------------------------

    execute_unit u_ex (.ex_i(de_q), .out_o(ex_out));

    // wrong-path slot in execute is dropped along with the younger stages
    pipe_reg #(.payload_t(wb_t)) u_wb (
        .clk(clk), .rst_n(rst_n), .flush_i(wb_q.redirect),
        .stall_i(1'b0), .bubble_i(1'b0), .d_i(ex_out), .q_o(wb_q)
    );

    assign wbus.valid = wb_q.valid;
    assign wbus.rd    = wb_q.we ? wb_q.rd : '0;
    assign wbus.data  = wb_q.we ? wb_q.result : '0;
    assign wbus.pc    = wb_q.pc;

    assign retire_valid_o = wbus.valid;
    assign retire_pc_o    = wbus.pc;
    assign retire_rd_o    = wbus.rd;
    assign retire_data_o  = wbus.data;

endmodule

//--- logic/rv_pkg.sv
package rv_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    // major opcode in instruction bits 6..2
    typedef enum logic [4:0] {
        OP_IMM = 5'b00100,
        AUIPC  = 5'b00101,
        OP     = 5'b01100,
        LUI    = 5'b01101,
        BRANCH = 5'b11000,
        JALR   = 5'b11001,
        JAL    = 5'b11011
    } opcode_e;

    localparam logic [6:0] ALU_SUB_FUNCT7 = 7'b0100000; // sub, sra, srai

    // ------------------------------------------------------------------
    // stage payloads
    // ------------------------------------------------------------------

    typedef struct packed {
        logic  valid;
        word_t instr;
        word_t pc;
    } fetch_t;

    typedef struct packed {
        logic       valid;
        word_t      instr;
        word_t      pc;
        opcode_e    opcode;
        reg_idx_t   rs1;
        reg_idx_t   rs2;
        reg_idx_t   rd;
        logic       we;
        logic [2:0] funct3;
        logic [6:0] funct7;
        word_t      imm;    // sign extended
        word_t      r1;     // operands after forwarding
        word_t      r2;
    } decoded_t;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        reg_idx_t rd;
        logic     we;
        word_t    result;
        logic     redirect;
        word_t    target;
    } wb_t;

endpackage

//--- logic/wb_if.sv
`timescale 1ns/100ps

interface wb_if import rv_pkg::*; ();

    logic     valid;
    reg_idx_t rd;    // zero when nothing is written
    word_t    data;
    word_t    pc;

    modport source (
        output valid, rd, data, pc
    );

    modport sink (
        input valid, rd, data, pc
    );

endinterface

//--- tests/rv_ref_model.svh
`ifndef RV_REF_MODEL_SVH
`define RV_REF_MODEL_SVH

word_t model_x [32];  // x0 is never written and stays zero
word_t model_pc;

// ----------------------------------------------------------------------
// instruction-level reference
// ----------------------------------------------------------------------

function automatic word_t alu_ref(word_t a, word_t b, logic [2:0] f3, logic alt);
    case (f3)
        3'b000:  return alt ? a - b : a + b;
        3'b001:  return a << b[4:0];
        3'b010:  return {31'b0, $signed(a) < $signed(b)};
        3'b011:  return {31'b0, a < b};
        3'b100:  return a ^ b;
        3'b101:  return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
        3'b110:  return a | b;
        default: return a & b;
    endcase
endfunction

function automatic logic branch_ref(word_t a, word_t b, logic [2:0] f3);
    case (f3)
        3'b000:  return a == b;
        3'b001:  return a != b;
        3'b100:  return $signed(a) < $signed(b);
        3'b101:  return $signed(a) >= $signed(b);
        3'b110:  return a < b;
        3'b111:  return a >= b;
        default: return 1'b0;
    endcase
endfunction

// one step on the model state, gives back the retire record
function automatic void ref_step(input word_t ins, output word_t pc, output reg_idx_t rd,
                                 output word_t data);
    word_t a, b, imm_i, imm_u, imm_b, imm_j, nxt, val;
    logic  wr;
    a     = model_x[ins[19:15]];
    b     = model_x[ins[24:20]];
    imm_i = {{20{ins[31]}}, ins[31:20]};
    imm_u = {ins[31:12], 12'b0};
    imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
    imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
    nxt   = model_pc + 32'd4;
    val   = '0;
    wr    = 1'b1;
    case (ins[6:0])
        7'b0110011: val = alu_ref(a, b, ins[14:12], ins[30]);
        7'b0010011: val = alu_ref(a, imm_i, ins[14:12], ins[30] && ins[14:12] == 3'b101);
        7'b0110111: val = imm_u;             // lui
        7'b0010111: val = model_pc + imm_u;  // auipc
        7'b1101111: begin                    // jal
            val = model_pc + 32'd4;
            nxt = model_pc + imm_j;
        end
        7'b1100111: begin                    // jalr
            val = model_pc + 32'd4;
            nxt = (a + imm_i) & ~32'd1;
        end
        7'b1100011: begin
            wr = 1'b0;
            if (branch_ref(a, b, ins[14:12])) begin
                nxt = model_pc + imm_b;
            end
        end
        default: wr = 1'b0;  // unknown opcode is a no-op
    endcase
    pc   = model_pc;
    rd   = (wr && ins[11:7] != 5'd0) ? ins[11:7] : 5'd0;
    data = (rd != 5'd0) ? val : '0;
    if (rd != 5'd0) begin
        model_x[rd] = val;
    end
    model_pc = nxt;
endfunction

// ----------------------------------------------------------------------
// encoders and program builders
// ----------------------------------------------------------------------

function automatic word_t enc_r(logic [6:0] f7, reg_idx_t rs2, reg_idx_t rs1, logic [2:0] f3,
                                reg_idx_t rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
endfunction

function automatic word_t enc_i(logic [11:0] imm, reg_idx_t rs1, logic [2:0] f3, reg_idx_t rd,
                                logic [6:0] op);
    return {imm, rs1, f3, rd, op};
endfunction

function automatic word_t enc_u(logic [19:0] imm, reg_idx_t rd, logic [6:0] op);
    return {imm, rd, op};
endfunction

function automatic word_t enc_b(logic [12:0] off, reg_idx_t rs1, reg_idx_t rs2, logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
endfunction

function automatic word_t enc_j(logic [20:0] off, reg_idx_t rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
endfunction

task automatic emit(input word_t w);
    prog.push_back(w);
endtask

task automatic build_alu_prog(input int n);
    word_t       r;
    reg_idx_t    rd, rs1, rs2, last;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [11:0] imm;
    prog.delete();
    for (int k = 1; k < 8; k++) begin
        r = rand32();
        emit(enc_i(r[11:0], 5'd0, 3'b000, reg_idx_t'(k), 7'b0010011));  // seed x1..x7
    end
    last = 5'd7;
    for (int k = 0; k < n; k++) begin
        r   = rand32();
        rd  = {2'b0, r[2:0]};
        rs1 = r[3] ? last : {2'b0, r[6:4]};  // often the previous result
        rs2 = r[7] ? last : {2'b0, r[10:8]};
        f3  = r[13:11];
        f7  = (r[14] && (f3 == 3'b000 || f3 == 3'b101)) ? 7'b0100000 : 7'b0;
        if (r[15]) begin
            emit(enc_r(f7, rs2, rs1, f3, rd));
        end else begin
            imm = r[27:16];
            if (f3 == 3'b001 || f3 == 3'b101) begin
                imm = {f7, r[20:16]};  // shamt in the low bits
            end
            emit(enc_i(imm, rs1, f3, rd, 7'b0010011));
        end
        last = rd;
    end
    emit(enc_j(21'd0, 5'd0));  // last instruction jumps to itself
endtask

task automatic build_upper_prog();
    prog.delete();
    emit(enc_u(20'h12345, 5'd1, 7'b0110111));
    emit(enc_u(20'hfffff, 5'd2, 7'b0110111));
    emit(enc_u(20'h00001, 5'd3, 7'b0010111));
    emit(enc_u(20'h80000, 5'd4, 7'b0010111));
    emit(enc_i(12'h678, 5'd1, 3'b000, 5'd5, 7'b0010011));
    emit(enc_r(7'b0, 5'd3, 5'd4, 3'b000, 5'd6));
    emit(enc_u(20'habcde, 5'd0, 7'b0110111));  // x0 target
    emit(enc_j(21'd0, 5'd0));
endtask

// taken case skips two wrong-path adds, not-taken case falls into one
task automatic branch_pair(input logic [2:0] f3, input reg_idx_t t1, t2, n1, n2);
    emit(enc_b(13'd12, t1, t2, f3));
    emit(enc_i(12'h111, 5'd10, 3'b000, 5'd10, 7'b0010011));
    emit(enc_i(12'h222, 5'd10, 3'b000, 5'd10, 7'b0010011));
    emit(enc_b(13'd8, n1, n2, f3));
    emit(enc_i(12'h001, 5'd11, 3'b000, 5'd11, 7'b0010011));
endtask

task automatic build_branch_prog();
    prog.delete();
    emit(enc_i(12'hffb, 5'd0, 3'b000, 5'd1, 7'b0010011));  // x1 = -5
    emit(enc_i(12'h007, 5'd0, 3'b000, 5'd2, 7'b0010011));  // x2 = 7
    emit(enc_i(12'h007, 5'd0, 3'b000, 5'd3, 7'b0010011));  // x3 = 7
    branch_pair(3'b000, 5'd2, 5'd3, 5'd1, 5'd2);  // beq
    branch_pair(3'b001, 5'd1, 5'd2, 5'd2, 5'd3);  // bne
    branch_pair(3'b100, 5'd1, 5'd2, 5'd2, 5'd1);  // blt
    branch_pair(3'b101, 5'd2, 5'd1, 5'd1, 5'd2);  // bge
    branch_pair(3'b110, 5'd2, 5'd1, 5'd1, 5'd2);  // bltu
    branch_pair(3'b111, 5'd1, 5'd2, 5'd2, 5'd1);  // bgeu
    emit(enc_j(21'd0, 5'd0));
endtask

task automatic build_jump_prog();
    prog.delete();
    emit(enc_j(21'd12, 5'd1));
    emit(enc_i(12'h333, 5'd0, 3'b000, 5'd9, 7'b0010011));  // wrong path
    emit(enc_i(12'h444, 5'd0, 3'b000, 5'd9, 7'b0010011));
    emit(enc_u(20'h00000, 5'd5, 7'b0010111));              // x5 = own pc
    emit(enc_i(12'h011, 5'd5, 3'b000, 5'd5, 7'b0010011));  // odd address
    emit(enc_i(12'h000, 5'd5, 3'b000, 5'd6, 7'b1100111));  // jalr clears bit 0
    emit(enc_i(12'h555, 5'd0, 3'b000, 5'd9, 7'b0010011));
    emit(enc_i(12'h000, 5'd6, 3'b000, 5'd7, 7'b0010011));  // reads the link
    emit(enc_j(21'd8, 5'd0));
    emit(enc_i(12'h666, 5'd0, 3'b000, 5'd9, 7'b0010011));
    emit(enc_j(21'd0, 5'd0));
endtask

`endif

//--- tests/tb_rv_core.sv
`timescale 1ns/100ps

module tb_rv_core import rv_pkg::*; ();

    localparam int    CLK_PERIOD = 40;
    localparam word_t START_PC   = 32'h0000_0100;
    localparam int    MEM_WORDS  = 256;

    logic     clk;
    logic     rst_n;
    logic     imem_ready_i;
    word_t    imem_rdata_i;
    logic     imem_valid_o;
    word_t    imem_addr_o;
    logic     retire_valid_o;
    word_t    retire_pc_o;
    reg_idx_t retire_rd_o;
    word_t    retire_data_o;

    word_t mem [MEM_WORDS];
    word_t prog [$];
    word_t p_alu [$];
    word_t p_upper [$];
    word_t p_branch [$];
    word_t p_jump [$];
    word_t rng_state = 32'd57;
    word_t end_pc;
    logic  ready_random = 1'b0;
    logic  checking = 1'b0;
    logic  done = 1'b0;
    int    retired, test_errors, errors, checks, tests, cur_test;
    int    run_limit = 0;  // cycles

    function automatic word_t rand32();
        word_t x;
        x = rng_state;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        rng_state = x;
        return x;
    endfunction

    `include "rv_ref_model.svh"

    function automatic word_t fill_word(word_t addr);
        return 32'hdead_0000 ^ addr;  // low bits 00 decode as no-op
    endfunction

    function automatic word_t imem_word(word_t addr);
        if (addr[31:10] == '0) begin
            return mem[addr[9:2]];
        end
        return fill_word(addr);
    endfunction

    rv_core #(.INITIAL_PC(START_PC)) UUT (
        .clk(clk), .rst_n(rst_n),
        .imem_ready_i(imem_ready_i), .imem_rdata_i(imem_rdata_i),
        .imem_valid_o(imem_valid_o), .imem_addr_o(imem_addr_o),
        .retire_valid_o(retire_valid_o), .retire_pc_o(retire_pc_o),
        .retire_rd_o(retire_rd_o), .retire_data_o(retire_data_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // instruction memory answers in the same cycle
    initial begin : drive
        word_t r;
        imem_ready_i = 1'b0;
        imem_rdata_i = '0;
        forever begin
            @(negedge clk);
            imem_rdata_i = imem_word(imem_addr_o);
            imem_ready_i = 1'b1;
            if (ready_random) begin
                r = rand32();
                imem_ready_i = r[3];
            end
        end
    end

    // ------------------------------------------------------------------
    // checks
    // ------------------------------------------------------------------

    task automatic check_word(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", name, got, exp);
            test_errors++;
        end
    endtask

    task automatic check_idx(input string name, input reg_idx_t got, input reg_idx_t exp);
        checks++;
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", name, got, exp);
            test_errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", name, got, exp);
            test_errors++;
        end
    endtask

    initial begin : compare
        word_t    exp_pc, exp_data;
        reg_idx_t exp_rd;
        forever begin
            @(negedge clk);
            if (checking && rst_n && retire_valid_o) begin
                ref_step(imem_word(model_pc), exp_pc, exp_rd, exp_data);
                check_word("retire_pc_o", retire_pc_o, exp_pc);
                check_idx("retire_rd_o", retire_rd_o, exp_rd);
                check_word("retire_data_o", retire_data_o, exp_data);
                retired++;
                if (exp_pc == end_pc) begin
                    checking = 1'b0;
                    done     = 1'b1;
                end
            end
        end
    end

    initial begin : watchdog
        wait (run_limit != 0);
        repeat (run_limit) @(negedge clk);
        $display("timeout: test %0d retired %0d instructions and never reached its last one",
                 cur_test, retired);
        $display("Simulation finished: FAIL");
        $finish;
    end

    // ------------------------------------------------------------------
    // test sequencing
    // ------------------------------------------------------------------

    task automatic reset_dut();
        @(negedge clk);
        rst_n = 1'b0;
        repeat (4) begin
            @(negedge clk);
            check_bit("retire_valid_o", retire_valid_o, 1'b0);
            check_bit("imem_valid_o", imem_valid_o, 1'b0);
        end
        rst_n = 1'b1;
        @(negedge clk);
        check_bit("imem_valid_o", imem_valid_o, 1'b1);
        check_word("imem_addr_o", imem_addr_o, START_PC);
    endtask

    task automatic finish_test(input int num, input string name);
        tests++;
        errors += test_errors;
        $display("test %0d %s: %0d retired, %0d errors", num, name, retired, test_errors);
    endtask

    task automatic run_test(input int num, input string name);
        cur_test    = num;
        test_errors = 0;
        retired     = 0;
        done        = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = fill_word(word_t'(i) << 2);
        end
        foreach (prog[k]) begin
            mem[(START_PC >> 2) + k] = prog[k];
        end
        end_pc = START_PC + 4 * (prog.size() - 1);
        for (int r = 0; r < 32; r++) begin
            model_x[r] = '0;
        end
        model_pc = START_PC;
        reset_dut();
        checking = 1'b1;  // first retire is three edges away
        while (!done) @(negedge clk);
        finish_test(num, name);
    endtask

    initial begin
        rst_n = 1'b0;
        build_alu_prog(40);
        p_alu = prog;
        build_upper_prog();
        p_upper = prog;
        build_branch_prog();
        p_branch = prog;
        build_jump_prog();
        p_jump = prog;
        run_limit = 20 * (2 * p_alu.size() + p_upper.size() + p_branch.size() + p_jump.size())
                    + 6 * 8;

        cur_test    = 1;
        test_errors = 0;
        retired     = 0;
        reset_dut();
        finish_test(1, "reset");
        prog = p_alu;
        run_test(2, "random alu");
        prog = p_upper;
        run_test(3, "lui auipc");
        prog = p_branch;
        run_test(4, "branches");
        prog = p_jump;
        run_test(5, "jal jalr");
        prog = p_alu;
        ready_random = 1'b1;
        run_test(6, "random alu, ready low");

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- verilog.f
+incdir+tests
logic/rv_pkg.sv
logic/wb_if.sv
logic/pipe_reg.sv
logic/fetch_unit.sv
logic/decoder.sv
logic/hazard_unit.sv
logic/reg_file.sv
logic/alu.sv
logic/execute_unit.sv
logic/rv_core.sv
tests/tb_rv_core.sv
